/* logic/mmio_defs.svh */
// Address map and sizing for the host MMIO subsystem
// Requests are naturally aligned and address bits 2:0 are ignored
// The scratch and line ranges must stay aligned to their own size
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// ====================
// Widths
// ====================
`define MMIO_ADDR_W 16
`define MMIO_TAG_W 8

// ====================
// Register map
// ====================
`define AFU_ID_VALUE 64'hc0de_5a1e_0001_0042
`define ADDR_ID 16'h0000
`define ADDR_LINE_COUNT 16'h0010
// Eight 64-bit scratch words, 0x100 to 0x13f
`define ADDR_SCRATCH_BASE 16'h0100
`define SCRATCH_WORDS 8
// Four 64-byte lines, 0x1000 to 0x10ff
`define ADDR_LINE_BASE 16'h1000
`define LINE_COUNT 4

`endif

/* logic/mmio_pkg.sv */
// Shared types for the host request stream and the MMIO data paths
// A write64 request carries its data in the low 64 bits of the data field
`include "mmio_defs.svh"

package mmio_pkg;

    // One 64-bit register word
    typedef logic [63:0] data64_t;

    // One full 512-bit line
    typedef logic [511:0] data512_t;

    // Request kind as seen on the host stream
    // Code 3 is unused, bridge treats it as a 64-bit write
    typedef enum logic [1:0] {
        read64   = 2'd0,
        write64  = 2'd1,
        write512 = 2'd2
    } req_kind_e;

    // Host request, one beat per transaction
    typedef struct packed {
        req_kind_e                 kind;
        logic [`MMIO_ADDR_W-1:0]   addr;
        logic [`MMIO_TAG_W-1:0]    tag;
        data512_t                  data;
    } host_req_t;

    // Read completion back to the host
    typedef struct packed {
        logic [`MMIO_TAG_W-1:0]    tag;
        data64_t                   data;
    } host_rsp_t;

endpackage

/* logic/axi_lite_if.sv */
// AXI-lite style channel bundle, single beat, no response codes
// Payload type is a parameter so one bundle serves the 64 and 512 bit ports
`timescale 1ns/1ps
`include "mmio_defs.svh"

interface axi_lite_if #(
    parameter type data_t = mmio_pkg::data64_t,
    parameter int  addr_w = `MMIO_ADDR_W
);

    // Write address channel
    logic              awvalid;
    logic              awready;
    logic [addr_w-1:0] awaddr;

    // Write data channel
    logic              wvalid;
    logic              wready;
    data_t             wdata;

    // Write response, no status bits carried
    logic              bvalid;
    logic              bready;

    // Read address channel
    logic              arvalid;
    logic              arready;
    logic [addr_w-1:0] araddr;

    // Read data channel
    logic              rvalid;
    logic              rready;
    data_t             rdata;

    // Manager side, issues requests
    modport manager (
        output awvalid, awaddr, wvalid, wdata, bready,
        output arvalid, araddr, rready,
        input  awready, wready, bvalid, arready, rvalid, rdata
    );

    // Subordinate side, the register block
    modport subordinate (
        input  awvalid, awaddr, wvalid, wdata, bready,
        input  arvalid, araddr, rready,
        output awready, wready, bvalid, arready, rvalid, rdata
    );

endinterface

/* logic/host_mmio_bridge.sv */
// Splits the host request stream onto a 64-bit read/write port and a
// 512-bit write-only port, one request in flight at a time
// Writes get no host response, reads return the request tag with the data
`timescale 1ns/1ps

module host_mmio_bridge (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  mmio_pkg::host_req_t  req,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output mmio_pkg::host_rsp_t  rsp,
    axi_lite_if.manager          mmio64,
    axi_lite_if.manager          mmio512_wr
);

    typedef enum logic [2:0] {
        st_idle,
        st_issue,
        st_wait_b,
        st_wait_r,
        st_hold_rsp
    } state_e;

    state_e              state;
    mmio_pkg::host_req_t req_q;
    mmio_pkg::data64_t   rdata_q;
    logic                aw_done;
    logic                w_done;

    // ====================
    // Port selection
    // ====================
    logic is_read;
    logic to_512;
    logic in_issue;
    logic aw_valid, aw_ready, aw_fire;
    logic w_valid, w_ready, w_fire;
    logic ar_fire, b_fire, r_fire;
    logic req_fire;

    assign req_fire = req_valid && req_ready;
    assign is_read  = req_q.kind == mmio_pkg::read64;
    assign to_512   = req_q.kind == mmio_pkg::write512;
    assign in_issue = state == st_issue;

    // AW and W are raised together and dropped independently
    assign aw_valid = in_issue && !is_read && !aw_done;
    assign w_valid  = in_issue && !is_read && !w_done;
    assign aw_ready = to_512 ? mmio512_wr.awready : mmio64.awready;
    assign w_ready  = to_512 ? mmio512_wr.wready : mmio64.wready;
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;

    assign b_fire  = (state == st_wait_b) && (to_512 ? mmio512_wr.bvalid : mmio64.bvalid);
    assign ar_fire = mmio64.arvalid && mmio64.arready;
    assign r_fire  = mmio64.rvalid && mmio64.rready;

    // 64-bit port, all five channels
    assign mmio64.awvalid = aw_valid && !to_512;
    assign mmio64.awaddr  = req_q.addr;
    assign mmio64.wvalid  = w_valid && !to_512;
    assign mmio64.wdata   = req_q.data[63:0];
    assign mmio64.bready  = (state == st_wait_b) && !to_512;
    assign mmio64.arvalid = in_issue && is_read;
    assign mmio64.araddr  = req_q.addr;
    assign mmio64.rready  = state == st_wait_r;

    // 512-bit port, write channels only, read side held idle
    assign mmio512_wr.awvalid = aw_valid && to_512;
    assign mmio512_wr.awaddr  = req_q.addr;
    assign mmio512_wr.wvalid  = w_valid && to_512;
    assign mmio512_wr.wdata   = req_q.data;
    assign mmio512_wr.bready  = (state == st_wait_b) && to_512;
    assign mmio512_wr.arvalid = 1'b0;
    assign mmio512_wr.araddr  = '0;
    assign mmio512_wr.rready  = 1'b0;

    // Host completion
    assign rsp_valid = state == st_hold_rsp;
    assign rsp.tag   = req_q.tag;
    assign rsp.data  = rdata_q;

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            req_ready <= 1'b1;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_fire) begin
                        state     <= st_issue;
                        req_ready <= 1'b0;
                        aw_done   <= 1'b0;
                        w_done    <= 1'b0;
                    end
                end
                st_issue: begin
                    if (is_read) begin
                        if (ar_fire) begin
                            state <= st_wait_r;
                        end
                    end else begin
                        if (aw_fire) begin
                            aw_done <= 1'b1;
                        end
                        if (w_fire) begin
                            w_done <= 1'b1;
                        end
                        // Both halves in, either this edge or earlier
                        if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                            state <= st_wait_b;
                        end
                    end
                end
                st_wait_b: begin
                    if (b_fire) begin
                        state     <= st_idle;
                        req_ready <= 1'b1;
                    end
                end
                st_wait_r: begin
                    if (r_fire) begin
                        state <= st_hold_rsp;
                    end
                end
                st_hold_rsp: begin
                    if (rsp_ready) begin
                        state     <= st_idle;
                        req_ready <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request and read data payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= req;
        end
        if (r_fire) begin
            rdata_q <= mmio64.rdata;
        end
    end

    // Held completion must not move under back-pressure
    a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

    // Ready only when idle with nothing left pending at the register block
    a_ready_idle: assert property (@(posedge clk) disable iff (reset)
        req_ready |-> state == st_idle && !mmio64.bvalid && !mmio64.rvalid
            && !mmio512_wr.bvalid);

endmodule

/* logic/afu_csr.sv */
// Accelerator register block behind the two MMIO ports
// Map offsets come from the defs header, bits 2:0 of an address are ignored
// Scratch index is address bits 5:3, line index bits 7:6, so the map
// sizes must not grow past eight words and four lines
`timescale 1ns/1ps
`include "mmio_defs.svh"

module afu_csr (
    input  logic              clk,
    input  logic              reset,
    axi_lite_if.subordinate   mmio64,
    axi_lite_if.subordinate   mmio512_wr
);

    localparam int addr_w = `MMIO_ADDR_W;

    // Register file and line buffer
    mmio_pkg::data64_t  scratch [`SCRATCH_WORDS];
    mmio_pkg::data512_t lines [`LINE_COUNT];
    mmio_pkg::data64_t  line_count;

    // Range checks, base addresses are size aligned
    function automatic logic in_scratch(input logic [addr_w-1:0] a);
        return (a >= `ADDR_SCRATCH_BASE) && (a < (`ADDR_SCRATCH_BASE + 8 * `SCRATCH_WORDS));
    endfunction

    function automatic logic in_lines(input logic [addr_w-1:0] a);
        return (a >= `ADDR_LINE_BASE) && (a < (`ADDR_LINE_BASE + 64 * `LINE_COUNT));
    endfunction

    // ====================
    // Write capture
    // ====================
    logic               aw64_got, w64_got, b64_valid;
    logic               aw512_got, w512_got, b512_valid;
    logic               r64_valid;
    logic [addr_w-1:0]  aw64_addr_q, aw512_addr_q;
    mmio_pkg::data64_t  w64_data_q, r64_data_q, rd64_word;
    mmio_pkg::data512_t w512_data_q;

    // Current write halves, either latched or arriving now
    logic               aw64_fire, w64_fire, wr64_commit;
    logic               aw512_fire, w512_fire, wr512_commit;
    logic               ar64_fire;
    logic [addr_w-1:0]  wr64_addr, wr512_addr;
    mmio_pkg::data64_t  wr64_data;
    mmio_pkg::data512_t wr512_data;

    assign aw64_fire   = mmio64.awvalid && mmio64.awready;
    assign w64_fire    = mmio64.wvalid && mmio64.wready;
    assign ar64_fire   = mmio64.arvalid && mmio64.arready;
    assign wr64_commit = (aw64_got || aw64_fire) && (w64_got || w64_fire);
    assign wr64_addr   = aw64_got ? aw64_addr_q : mmio64.awaddr;
    assign wr64_data   = w64_got ? w64_data_q : mmio64.wdata;

    assign aw512_fire   = mmio512_wr.awvalid && mmio512_wr.awready;
    assign w512_fire    = mmio512_wr.wvalid && mmio512_wr.wready;
    assign wr512_commit = (aw512_got || aw512_fire) && (w512_got || w512_fire);
    assign wr512_addr   = aw512_got ? aw512_addr_q : mmio512_wr.awaddr;
    assign wr512_data   = w512_got ? w512_data_q : mmio512_wr.wdata;

    // Readies drop while a response waits
    assign mmio64.awready = !aw64_got && !b64_valid && !r64_valid;
    assign mmio64.wready  = !w64_got && !b64_valid && !r64_valid;
    assign mmio64.arready = !b64_valid && !r64_valid;
    assign mmio64.bvalid  = b64_valid;
    assign mmio64.rvalid  = r64_valid;
    assign mmio64.rdata   = r64_data_q;

    // Write-only port, read side stays quiet
    assign mmio512_wr.awready = !aw512_got && !b512_valid;
    assign mmio512_wr.wready  = !w512_got && !b512_valid;
    assign mmio512_wr.bvalid  = b512_valid;
    assign mmio512_wr.arready = 1'b0;
    assign mmio512_wr.rvalid  = 1'b0;
    assign mmio512_wr.rdata   = '0;

    // Handshake state for both ports
    always_ff @(posedge clk) begin
        if (reset) begin
            {aw64_got, w64_got, b64_valid, r64_valid} <= '0;
            {aw512_got, w512_got, b512_valid} <= '0;
        end else begin
            aw64_got  <= (aw64_got || aw64_fire) && !wr64_commit;
            w64_got   <= (w64_got || w64_fire) && !wr64_commit;
            b64_valid <= wr64_commit || (b64_valid && !mmio64.bready);
            r64_valid <= ar64_fire || (r64_valid && !mmio64.rready);
            aw512_got  <= (aw512_got || aw512_fire) && !wr512_commit;
            w512_got   <= (w512_got || w512_fire) && !wr512_commit;
            b512_valid <= wr512_commit || (b512_valid && !mmio512_wr.bready);
        end
    end

    // Latched halves and read data
    always_ff @(posedge clk) begin
        if (aw64_fire) aw64_addr_q <= mmio64.awaddr;
        if (w64_fire) w64_data_q <= mmio64.wdata;
        if (aw512_fire) aw512_addr_q <= mmio512_wr.awaddr;
        if (w512_fire) w512_data_q <= mmio512_wr.wdata;
        if (ar64_fire) r64_data_q <= rd64_word;
    end

    // ====================
    // Register updates
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SCRATCH_WORDS; i++) scratch[i] <= '0;
            for (int i = 0; i < `LINE_COUNT; i++) lines[i] <= '0;
            line_count <= '0;
        end else begin
            // ID, counter and holes ignore 64-bit writes
            if (wr64_commit) begin
                if (in_scratch(wr64_addr)) begin
                    scratch[wr64_addr[5:3]] <= wr64_data;
                end else if (in_lines(wr64_addr)) begin
                    lines[wr64_addr[7:6]][{wr64_addr[5:3], 6'd0} +: 64] <= wr64_data;
                end
            end
            // Every line write counts, mapped or not
            if (wr512_commit) begin
                line_count <= line_count + 64'd1;
                if (in_lines(wr512_addr)) begin
                    lines[wr512_addr[7:6]] <= wr512_data;
                end
            end
        end
    end

    // Read decode, sampled on the AR edge
    always_comb begin
        rd64_word = '0;
        if ((mmio64.araddr >> 3) == (`ADDR_ID >> 3)) begin
            rd64_word = `AFU_ID_VALUE;
        end else if ((mmio64.araddr >> 3) == (`ADDR_LINE_COUNT >> 3)) begin
            rd64_word = line_count;
        end else if (in_scratch(mmio64.araddr)) begin
            rd64_word = scratch[mmio64.araddr[5:3]];
        end else if (in_lines(mmio64.araddr)) begin
            rd64_word = lines[mmio64.araddr[7:6]][{mmio64.araddr[5:3], 6'd0} +: 64];
        end
    end

    // Responses hold until the bridge takes them
    a_b64_hold: assert property (@(posedge clk) disable iff (reset)
        mmio64.bvalid && !mmio64.bready |=> mmio64.bvalid);
    a_b512_hold: assert property (@(posedge clk) disable iff (reset)
        mmio512_wr.bvalid && !mmio512_wr.bready |=> mmio512_wr.bvalid);
    a_r64_hold: assert property (@(posedge clk) disable iff (reset)
        mmio64.rvalid && !mmio64.rready |=> mmio64.rvalid && $stable(mmio64.rdata));

endmodule

/* logic/afu_top.sv */
// Host interface top level, single clock, synchronous active high reset
// Requests are handled one at a time, only reads produce a response
`timescale 1ns/1ps
`include "mmio_defs.svh"

module afu_top (
    input  logic                    clk,
    input  logic                    reset,

    // Host request stream
    input  logic                    req_valid,
    output logic                    req_ready,
    input  mmio_pkg::req_kind_e     req_kind,
    input  logic [`MMIO_ADDR_W-1:0] req_addr,
    input  logic [`MMIO_TAG_W-1:0]  req_tag,
    input  mmio_pkg::data512_t      req_data,

    // Read completions
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [`MMIO_TAG_W-1:0]  rsp_tag,
    output mmio_pkg::data64_t       rsp_data
);

    mmio_pkg::host_req_t req;
    mmio_pkg::host_rsp_t rsp;

    // Pack the plain request ports
    assign req.kind = req_kind;
    assign req.addr = req_addr;
    assign req.tag  = req_tag;
    assign req.data = req_data;

    // Unpack the completion
    assign rsp_tag  = rsp.tag;
    assign rsp_data = rsp.data;

    // ====================
    // MMIO ports
    // ====================
    // 64-bit read/write port
    axi_lite_if #(.data_t(mmio_pkg::data64_t), .addr_w(`MMIO_ADDR_W)) mmio64 ();

    // 512-bit write-only port
    axi_lite_if #(.data_t(mmio_pkg::data512_t), .addr_w(`MMIO_ADDR_W)) mmio512_wr ();

    host_mmio_bridge bridge (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .mmio64     (mmio64.manager),
        .mmio512_wr (mmio512_wr.manager)
    );

    afu_csr csr (
        .clk        (clk),
        .reset      (reset),
        .mmio64     (mmio64.subordinate),
        .mmio512_wr (mmio512_wr.subordinate)
    );

endmodule

/* bench/afu_tb.sv */
// Random-stimulus testbench for the host MMIO top level
// One request is in flight at a time, so the model is updated at issue time
// Read responses are checked in issue order against a queue of expectations
// Run length is bounded by a watchdog scaled to the operation count
`timescale 1ns/1ps
`include "mmio_defs.svh"

module afu_tb;

    localparam int num_ops = 400;
    localparam int limit_cycles = (num_ops + 16) * 40;

    logic                    clk;
    logic                    reset;
    logic                    req_valid;
    logic                    req_ready;
    mmio_pkg::req_kind_e     req_kind;
    logic [`MMIO_ADDR_W-1:0] req_addr;
    logic [`MMIO_TAG_W-1:0]  req_tag;
    mmio_pkg::data512_t      req_data;
    logic                    rsp_valid;
    logic                    rsp_ready;
    logic [`MMIO_TAG_W-1:0]  rsp_tag;
    mmio_pkg::data64_t       rsp_data;

    // Reference model of the register block
    mmio_pkg::data64_t  model_scratch [`SCRATCH_WORDS];
    mmio_pkg::data512_t model_lines [`LINE_COUNT];
    mmio_pkg::data64_t  model_count;

    // Pending reads, oldest first
    mmio_pkg::data64_t      exp_data_q [$];
    logic [`MMIO_TAG_W-1:0] exp_tag_q [$];
    string                  exp_name_q [$];

    int errors;
    int reads_done;

    afu_top dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_kind  (req_kind),
        .req_addr  (req_addr),
        .req_tag   (req_tag),
        .req_data  (req_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ====================
    // Checker and model
    // ====================
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Expected read value, straight from the address map
    function automatic mmio_pkg::data64_t model_read(input logic [`MMIO_ADDR_W-1:0] addr);
        int word;
        int off;
        word = addr / 8;
        if (word == `ADDR_ID / 8) begin
            return `AFU_ID_VALUE;
        end
        if (word == `ADDR_LINE_COUNT / 8) begin
            return model_count;
        end
        if (addr >= `ADDR_SCRATCH_BASE && addr < `ADDR_SCRATCH_BASE + 8 * `SCRATCH_WORDS) begin
            return model_scratch[word - `ADDR_SCRATCH_BASE / 8];
        end
        if (addr >= `ADDR_LINE_BASE && addr < `ADDR_LINE_BASE + 64 * `LINE_COUNT) begin
            off = addr - `ADDR_LINE_BASE;
            // Byte offset in the line times 8 gives the bit offset
            return model_lines[off / 64][(off % 64) * 8 +: 64];
        end
        return '0;
    endfunction

    function automatic mmio_pkg::data512_t rand_line();
        mmio_pkg::data512_t v;
        for (int i = 0; i < 16; i++) begin
            v[i * 32 +: 32] = $urandom;
        end
        return v;
    endfunction

    // Word address well clear of every mapped range, or the hole next to the ID
    function automatic logic [`MMIO_ADDR_W-1:0] rand_unmapped();
        if ($urandom_range(0, 3) == 0) begin
            return 16'h0008;
        end
        return 16'h4000 | 16'($urandom & 32'h3ff8);
    endfunction

    // ====================
    // Request driver
    // ====================
    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input mmio_pkg::req_kind_e kind,
                            input logic [`MMIO_ADDR_W-1:0] addr,
                            input mmio_pkg::data512_t data, input string name);
        logic [`MMIO_TAG_W-1:0] tag;
        tag = `MMIO_TAG_W'($urandom);
        if (kind == mmio_pkg::read64) begin
            exp_data_q.push_back(model_read(addr));
            exp_tag_q.push_back(tag);
            exp_name_q.push_back(name);
        end
        req_valid = 1'b1;
        req_kind  = kind;
        req_addr  = addr;
        req_tag   = tag;
        req_data  = data;
        while (!req_ready) @(negedge clk);
        // Ready seen high here, so the handshake lands on the next rising edge
        @(negedge clk);
        req_valid = 1'b0;
        req_data  = '0;
    endtask

    task automatic do_read(input string name, input logic [`MMIO_ADDR_W-1:0] addr);
        send_req(mmio_pkg::read64, addr, '0, name);
    endtask

    task automatic do_write64(input logic [`MMIO_ADDR_W-1:0] addr,
                              input mmio_pkg::data64_t data);
        int off;
        if (addr >= `ADDR_SCRATCH_BASE && addr < `ADDR_SCRATCH_BASE + 8 * `SCRATCH_WORDS) begin
            model_scratch[(addr - `ADDR_SCRATCH_BASE) / 8] = data;
        end else if (addr >= `ADDR_LINE_BASE && addr < `ADDR_LINE_BASE + 64 * `LINE_COUNT) begin
            off = addr - `ADDR_LINE_BASE;
            model_lines[off / 64][(off % 64) * 8 +: 64] = data;
        end
        send_req(mmio_pkg::write64, addr, {448'd0, data}, "write64");
    endtask

    task automatic do_write512(input logic [`MMIO_ADDR_W-1:0] addr,
                               input mmio_pkg::data512_t data);
        // Every line write is counted, even outside the line range
        model_count = model_count + 64'd1;
        if (addr >= `ADDR_LINE_BASE && addr < `ADDR_LINE_BASE + 64 * `LINE_COUNT) begin
            model_lines[(addr - `ADDR_LINE_BASE) / 64] = data;
        end
        send_req(mmio_pkg::write512, addr, data, "write512");
    endtask

    // ====================
    // Back-pressure and response checks
    // ====================
    initial begin
        string name;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = !reset && ($urandom_range(0, 3) != 0);
            // Valid and ready now both hold through the next rising edge
            if (rsp_valid && rsp_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("Read response with tag %h arrived with no read pending", rsp_tag);
                    errors++;
                end else begin
                    name = exp_name_q.pop_front();
                    check_value({name, "_tag"}, 64'(exp_tag_q.pop_front()), 64'(rsp_tag));
                    check_value(name, exp_data_q.pop_front(), rsp_data);
                    reads_done++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (limit_cycles) @(posedge clk);
        errors++;
        $display("Watchdog expired after %0d cycles with %0d reads outstanding",
                 limit_cycles, exp_data_q.size());
        $display("Errors: %0d, reads checked: %0d", errors, reads_done);
        $display("Verification failed");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        int sel;
        void'($urandom(32'h89ea));
        errors     = 0;
        reads_done = 0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_kind   = mmio_pkg::read64;
        req_addr   = '0;
        req_tag    = '0;
        req_data   = '0;
        model_count = '0;
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            model_scratch[i] = '0;
        end
        for (int i = 0; i < `LINE_COUNT; i++) begin
            model_lines[i] = '0;
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Idle state straight out of reset
        check_value("reset_rsp_valid", 64'd0, 64'(rsp_valid));
        check_value("reset_req_ready", 64'd1, 64'(req_ready));
        do_read("read_id", `ADDR_ID);

        for (int n = 0; n < num_ops; n++) begin
            sel = $urandom_range(0, 9);
            case (sel)
                0: do_read("read_id", `ADDR_ID);
                1: do_read("read_count", `ADDR_LINE_COUNT);
                2, 3: begin
                    req_addr = 16'(`ADDR_SCRATCH_BASE + 8 * $urandom_range(0, 7));
                    if ($urandom_range(0, 1) == 1) do_write64(req_addr, {$urandom, $urandom});
                    else do_read("read_scratch", req_addr);
                end
                4: do_write512(16'(`ADDR_LINE_BASE + 64 * $urandom_range(0, 3)), rand_line());
                5, 6: begin
                    req_addr = 16'(`ADDR_LINE_BASE + 8 * $urandom_range(0, 31));
                    if ($urandom_range(0, 2) == 0) do_write64(req_addr, {$urandom, $urandom});
                    else do_read("read_line_word", req_addr);
                end
                7: begin
                    req_addr = rand_unmapped();
                    if ($urandom_range(0, 1) == 1) do_write64(req_addr, {$urandom, $urandom});
                    else do_read("read_unmapped", req_addr);
                end
                // Writes the block must ignore
                8: begin
                    req_addr = ($urandom_range(0, 1) == 1) ? `ADDR_ID : `ADDR_LINE_COUNT;
                    do_write64(req_addr, {$urandom, $urandom});
                end
                default: do_write512(16'h2000 | 16'($urandom & 32'h0fc0), rand_line());
            endcase
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end

        // Final sweep of the counter and every scratch word
        do_read("final_count", `ADDR_LINE_COUNT);
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            do_read("final_scratch", 16'(`ADDR_SCRATCH_BASE + 8 * i));
        end
        while (exp_data_q.size() != 0 || !req_ready) @(negedge clk);

        $display("Errors: %0d, reads checked: %0d", errors, reads_done);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/mmio_pkg.sv
logic/axi_lite_if.sv
logic/host_mmio_bridge.sv
logic/afu_csr.sv
logic/afu_top.sv
bench/afu_tb.sv

/* Makefile */
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module afu_tb -Mdir $(OBJ_DIR) -o afu_tb

run: compile
	./$(OBJ_DIR)/afu_tb > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "Verification failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
